// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tb_niuCore
FILELIST = niuCore.f
OBJDIR = obj_dir
SIM = $(OBJDIR)/V$(TOP)
LOG = sim.log
SOURCES = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "Simulation did not finish"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: niuAlu.sv
`default_nettype none

module niuAlu (
    input  logic          clk,
    input  niuPkg::ctrl_t ctrl,
    input  niuPkg::word_t bus,
    output niuPkg::word_t aluResult,
    output logic          aluFlag
);
    import niuPkg::*;

    word_t opA;
    word_t opB;
    logic [$clog2(wordSize)-1:0] shamt;

    always_ff @(posedge clk) begin
        if (ctrl.ldA) begin
            opA <= bus;
        end
        if (ctrl.ldB) begin
            opB <= bus;
        end
    end

    assign shamt = opB[$clog2(wordSize)-1:0];   // Low five bits only

    always_comb begin
        case (ctrl.aluFunc)
            aluSub: aluResult = opA - opB;
            aluAdd: aluResult = opA + opB;
            aluNot: aluResult = ~opA;
            aluAnd: aluResult = opA & opB;
            aluOr: aluResult = opA | opB;
            aluXor: aluResult = opA ^ opB;
            aluSul, aluSsl: aluResult = opA << shamt;   // Same result either way
            aluSur: aluResult = opA >> shamt;
            aluSsr: aluResult = word_t'($signed(opA) >>> shamt);
            aluEq: aluResult = word_t'(opA == opB);
            aluNeq: aluResult = word_t'(opA != opB);
            aluLt: aluResult = word_t'($signed(opA) < $signed(opB));
            aluLeq: aluResult = word_t'($signed(opA) <= $signed(opB));
            default: aluResult = '0;
        endcase
    end

    assign aluFlag = aluResult[0];   // Branch decision

endmodule

`default_nettype wire

// File: niuControl.sv
`default_nettype none

module niuControl (
    input  logic                 clk,
    input  logic                 reset,
    input  niuPkg::instrFields_t fields,
    input  logic                 aluFlag,
    output niuPkg::ctrl_t        ctrl,
    output logic                 halted
);
    import niuPkg::*;

    ctrlState_t state;
    ctrlState_t stateNext;
    ctrl_t ctrlNext;
    logic isAlur;

    assign isAlur = (fields.op1 == opAlur);
    assign halted = (state == sHalt);

    always_comb begin
        stateNext = state;
        case (state)
            // Strobes are registered, so the first fetch after reset waits a cycle
            sFetch: stateNext = ctrl.ldIr ? sDecode : sFetch;
            sDecode: begin
                case (fields.op1)
                    opAlur: begin
                        case (fields.op2)
                            aluSub, aluAdd, aluNot, aluAnd, aluOr, aluXor,
                            aluSul, aluSsl, aluSur, aluSsr,
                            aluEq, aluNeq, aluLt, aluLeq: stateNext = sAluB;
                            default: stateNext = sHalt;   // Multiply, divide and unknown
                        endcase
                    end
                    opAddi, opAndi, opOri, opXori,
                    opSuli, opSsli, opSuri, opSsri: stateNext = sAluB;
                    opLw, opSw: stateNext = sMemA;
                    opBeq, opBne, opBlt, opBle: stateNext = sBrA;
                    opJal: stateNext = sJalLink;
                    default: stateNext = sHalt;
                endcase
            end
            sAluB: stateNext = sAluA;
            sAluA: stateNext = sAluWb;
            sMemA: stateNext = sMemB;
            sMemB: stateNext = sMemAddr;
            sMemAddr: stateNext = (fields.op1 == opLw) ? sLwWait : sSwWr;
            sLwWait: stateNext = sLwWb;   // MDR catches the read
            sBrA: stateNext = sBrB;
            sBrB: stateNext = sBrCmp;
            sBrCmp: stateNext = aluFlag ? sBrPc : sFetch;
            sBrPc: stateNext = sBrOff;
            sBrOff: stateNext = sBrAdd;
            sJalLink: stateNext = sJalJump;
            sHalt: stateNext = sHalt;
            default: stateNext = sFetch;   // sAluWb, sLwWb, sSwWr, sBrAdd, sJalJump
        endcase
    end

    // Strobes for the state about to be entered
    always_comb begin
        ctrlNext = '0;
        case (stateNext)
            sFetch: begin
                ctrlNext.ldIr = 1'b1;
                ctrlNext.incPc = 1'b1;
            end
            sAluB: begin
                ctrlNext.ldB = 1'b1;
                ctrlNext.busSrc = isAlur ? busReg : busImm;
                ctrlNext.regSel = fields.ry;
            end
            sAluA, sMemA, sBrA: begin
                ctrlNext.ldA = 1'b1;
                ctrlNext.busSrc = busReg;
                ctrlNext.regSel = fields.rx;
            end
            sAluWb: begin
                ctrlNext.wrReg = 1'b1;
                ctrlNext.busSrc = busAlu;
                ctrlNext.regSel = isAlur ? fields.rz : fields.ry;
                ctrlNext.aluFunc = isAlur ? fields.op2 : aluFunc_t'(fields.op1);
            end
            sMemB: begin
                ctrlNext.ldB = 1'b1;
                ctrlNext.busSrc = busImm;
            end
            sMemAddr: begin
                ctrlNext.ldMar = 1'b1;
                ctrlNext.busSrc = busAlu;
                ctrlNext.aluFunc = aluAdd;   // rx + imm
            end
            sLwWb: begin
                ctrlNext.wrReg = 1'b1;
                ctrlNext.busSrc = busMem;
                ctrlNext.regSel = fields.ry;
            end
            sSwWr: begin
                ctrlNext.wrMem = 1'b1;
                ctrlNext.busSrc = busReg;
                ctrlNext.regSel = fields.ry;
            end
            sBrB: begin
                ctrlNext.ldB = 1'b1;
                ctrlNext.busSrc = busReg;
                ctrlNext.regSel = fields.ry;
            end
            sBrCmp: begin
                case (fields.op1)
                    opBne: ctrlNext.aluFunc = aluNeq;
                    opBlt: ctrlNext.aluFunc = aluLt;
                    opBle: ctrlNext.aluFunc = aluLeq;
                    default: ctrlNext.aluFunc = aluEq;
                endcase
            end
            sBrPc: begin
                ctrlNext.ldA = 1'b1;
                ctrlNext.busSrc = busPc;   // Already points past the branch
            end
            sBrOff: begin
                ctrlNext.ldB = 1'b1;
                ctrlNext.busSrc = busImmShifted;
            end
            sBrAdd: begin
                ctrlNext.ldPc = 1'b1;
                ctrlNext.busSrc = busAlu;
                ctrlNext.aluFunc = aluAdd;
            end
            sJalLink: begin
                ctrlNext.wrReg = 1'b1;
                ctrlNext.busSrc = busPc;
                ctrlNext.regSel = fields.ry;
            end
            sJalJump: begin
                ctrlNext.ldPc = 1'b1;
                ctrlNext.busSrc = busReg;
                ctrlNext.regSel = fields.rx;
            end
            default: ctrlNext = '0;   // sDecode, sLwWait, sHalt
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= sFetch;
            ctrl <= '0;
        end else begin
            state <= stateNext;
            ctrl <= ctrlNext;
        end
    end

    // PC has a single source per cycle
    pcLoadExclusive: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.ldPc && ctrl.incPc));

endmodule

`default_nettype wire

// File: niuCore.f
niuPkg.sv
niuControl.sv
niuFetch.sv
niuRegFile.sv
niuAlu.sv
niuDataMem.sv
niuCore.sv
tb_niuCore.sv

// File: niuCore.sv
`default_nettype none

module niuCore (
    input  logic              clk,
    input  logic              reset,
    input  logic              progWe,
    input  niuPkg::memIndex_t progAddr,
    input  niuPkg::word_t     progData,
    input  logic [9:0]        switches,
    output logic [9:0]        ledOut,
    output logic              halted
);
    import niuPkg::*;

    ctrl_t ctrl;
    instrFields_t fields;
    word_t bus;
    word_t pc;
    word_t regData;
    word_t aluResult;
    word_t readData;
    word_t immExt;
    logic aluFlag;

    assign immExt = {{(wordSize-immBits){fields.imm[immBits-1]}}, fields.imm};

    // Single internal bus
    always_comb begin
        case (ctrl.busSrc)
            busPc: bus = pc;
            busReg: bus = regData;
            busMem: bus = readData;
            busAlu: bus = aluResult;
            busImm: bus = immExt;
            busImmShifted: bus = immExt << byteOffset;   // Word offset to bytes
            default: bus = '0;
        endcase
    end

    niuControl i_control (
        .clk     (clk),
        .reset   (reset),
        .fields  (fields),
        .aluFlag (aluFlag),
        .ctrl    (ctrl),
        .halted  (halted)
    );

    niuFetch i_fetch (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (ctrl),
        .bus      (bus),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .pc       (pc),
        .fields   (fields)
    );

    niuRegFile i_regFile (
        .clk     (clk),
        .reset   (reset),
        .ctrl    (ctrl),
        .bus     (bus),
        .regData (regData)
    );

    niuAlu i_alu (
        .clk       (clk),
        .ctrl      (ctrl),
        .bus       (bus),
        .aluResult (aluResult),
        .aluFlag   (aluFlag)
    );

    niuDataMem i_dataMem (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (ctrl),
        .bus      (bus),
        .switches (switches),
        .readData (readData),
        .ledOut   (ledOut)
    );

endmodule

`default_nettype wire

// File: niuDataMem.sv
`default_nettype none

module niuDataMem (
    input  logic          clk,
    input  logic          reset,
    input  niuPkg::ctrl_t ctrl,
    input  niuPkg::word_t bus,
    input  logic [9:0]    switches,
    output niuPkg::word_t readData,
    output logic [9:0]    ledOut
);
    import niuPkg::*;

    word_t dmem [dmemWords];
    word_t mar;
    memIndex_t marIndex;
    logic isLed;

    assign marIndex = mar[memIndexBits+byteOffset-1:byteOffset];
    assign isLed = (mar == ledAddress);

    always_ff @(posedge clk) begin
        if (ctrl.ldMar) begin
            mar <= bus;
        end
    end

    // MDR follows MAR every cycle
    always_ff @(posedge clk) begin
        if (ctrl.wrMem && !isLed) begin
            dmem[marIndex] <= bus;
        end
        if (mar == switchAddress) begin
            readData <= word_t'(switches);
        end else begin
            readData <= dmem[marIndex];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ledOut <= '0;
        end else if (ctrl.wrMem && isLed) begin
            ledOut <= bus[9:0];
        end
    end

    // SW has no byte lanes and needs a word address
    storeAligned: assert property (@(posedge clk) disable iff (reset)
        ctrl.wrMem |-> mar[byteOffset-1:0] == '0);

endmodule

`default_nettype wire

// File: niuFetch.sv
`default_nettype none

module niuFetch (
    input  logic                 clk,
    input  logic                 reset,
    input  niuPkg::ctrl_t        ctrl,
    input  niuPkg::word_t        bus,
    input  logic                 progWe,
    input  niuPkg::memIndex_t    progAddr,
    input  niuPkg::word_t        progData,
    output niuPkg::word_t        pc,
    output niuPkg::instrFields_t fields
);
    import niuPkg::*;

    word_t imem [imemWords];
    word_t ir;
    memIndex_t pcIndex;

    assign pcIndex = pc[memIndexBits+byteOffset-1:byteOffset];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= pcStart;
        end else if (ctrl.ldPc) begin
            pc <= bus;
        end else if (ctrl.incPc) begin
            pc <= pc + instrBytes;
        end
    end

    // Program loader only writes while the core sits in reset
    always_ff @(posedge clk) begin
        if (reset && progWe) begin
            imem[progAddr] <= progData;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.ldIr) begin
            ir <= imem[pcIndex];
        end
    end

    assign fields.op1 = ir[31:27];
    assign fields.rx = ir[26:22];
    assign fields.ry = ir[21:17];
    assign fields.rz = ir[16:12];   // Overlaps imm
    assign fields.imm = ir[immBits-1:0];
    assign fields.op2 = ir[4:0];

    // Jump and branch targets must land on a word
    pcAligned: assert property (@(posedge clk) disable iff (reset)
        pc[byteOffset-1:0] == '0);

endmodule

`default_nettype wire

// File: niuPkg.sv
`default_nettype none

package niuPkg;

    localparam int wordSize = 32;
    localparam int instrBytes = 4;                    // PC step
    localparam int byteOffset = $clog2(instrBytes);   // Byte bits below the word index
    localparam int regCount = 32;
    localparam int immBits = 17;
    localparam int imemWords = 2048;
    localparam int dmemWords = 2048;
    localparam int memIndexBits = $clog2(imemWords);

    typedef logic [wordSize-1:0] word_t;
    typedef logic [$clog2(regCount)-1:0] regIdx_t;
    typedef logic [4:0] opcode_t;
    typedef logic [4:0] aluFunc_t;
    typedef logic [immBits-1:0] imm_t;
    typedef logic [memIndexBits-1:0] memIndex_t;

    // Primary opcodes
    localparam opcode_t opAlur = 5'b00000;   // Register ALU op, function in op2
    localparam opcode_t opAddi = 5'b00001;
    localparam opcode_t opAndi = 5'b00101;
    localparam opcode_t opOri = 5'b00110;
    localparam opcode_t opXori = 5'b00111;
    localparam opcode_t opSuli = 5'b01000;
    localparam opcode_t opSsli = 5'b01001;
    localparam opcode_t opSuri = 5'b01010;
    localparam opcode_t opSsri = 5'b01011;
    localparam opcode_t opLw = 5'b10000;
    localparam opcode_t opSw = 5'b10011;
    localparam opcode_t opBeq = 5'b11000;
    localparam opcode_t opBne = 5'b11001;
    localparam opcode_t opBlt = 5'b11010;
    localparam opcode_t opBle = 5'b11011;
    localparam opcode_t opJal = 5'b11111;

    // ALU functions, immediate opcodes share these codes
    localparam aluFunc_t aluSub = 5'b00000;
    localparam aluFunc_t aluAdd = 5'b00001;
    localparam aluFunc_t aluNot = 5'b00100;
    localparam aluFunc_t aluAnd = 5'b00101;
    localparam aluFunc_t aluOr = 5'b00110;
    localparam aluFunc_t aluXor = 5'b00111;
    localparam aluFunc_t aluSul = 5'b01000;
    localparam aluFunc_t aluSsl = 5'b01001;
    localparam aluFunc_t aluSur = 5'b01010;
    localparam aluFunc_t aluSsr = 5'b01011;
    localparam aluFunc_t aluEq = 5'b10000;
    localparam aluFunc_t aluNeq = 5'b10001;
    localparam aluFunc_t aluLt = 5'b10010;
    localparam aluFunc_t aluLeq = 5'b10011;

    // Memory-mapped ports
    localparam word_t ledAddress = 32'hFFFF0020;
    localparam word_t switchAddress = 32'hFFFF0120;

    localparam word_t pcStart = 32'h0;

    typedef enum logic [2:0] {
        busNone,
        busPc,
        busReg,
        busMem,
        busAlu,
        busImm,
        busImmShifted     // Immediate times instrBytes, for branches
    } busSrc_t;

    typedef struct packed {
        logic     ldPc;
        logic     incPc;
        logic     ldIr;
        logic     wrReg;
        logic     ldA;
        logic     ldB;
        logic     ldMar;
        logic     wrMem;
        busSrc_t  busSrc;
        regIdx_t  regSel;
        aluFunc_t aluFunc;
    } ctrl_t;

    typedef struct packed {
        opcode_t  op1;
        regIdx_t  rx;
        regIdx_t  ry;
        regIdx_t  rz;
        imm_t     imm;
        aluFunc_t op2;
    } instrFields_t;

    typedef enum logic [4:0] {
        sFetch,
        sDecode,
        sAluB,
        sAluA,
        sAluWb,
        sMemA,
        sMemB,
        sMemAddr,
        sLwWait,
        sLwWb,
        sSwWr,
        sBrA,
        sBrB,
        sBrCmp,
        sBrPc,
        sBrOff,
        sBrAdd,
        sJalLink,
        sJalJump,
        sHalt
    } ctrlState_t;

endpackage

`default_nettype wire

// File: niuRegFile.sv
`default_nettype none

module niuRegFile (
    input  logic          clk,
    input  logic          reset,
    input  niuPkg::ctrl_t ctrl,
    input  niuPkg::word_t bus,
    output niuPkg::word_t regData
);
    import niuPkg::*;

    word_t regs [regCount];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.wrReg) begin
            regs[ctrl.regSel] <= bus;
        end
    end

    // Read and write share the same select
    assign regData = regs[ctrl.regSel];

endmodule

`default_nettype wire

// File: tb_niuCore.sv
`default_nettype none

module tb_niuCore;
    timeunit 1ns;
    timeprecision 1ps;
    import niuPkg::*;

    localparam word_t lfsrSeed = 32'h4400f0dc;
    localparam word_t lfsrTaps = 32'h80200003;
    localparam word_t haltWord = {5'b11110, 27'd0};   // Unused primary opcode
    localparam int runLimit = 1000;                   // Cycles allowed per program

    logic clk;
    logic reset;
    logic progWe;
    memIndex_t progAddr;
    word_t progData;
    logic [9:0] switches;
    logic [9:0] ledOut;
    logic halted;

    word_t lfsr;
    word_t progWords[$];
    int checkCount;
    int errorCount;
    int timeoutCount;

    niuCore i_niuCore (
        .clk      (clk),
        .reset    (reset),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .switches (switches),
        .ledOut   (ledOut),
        .halted   (halted)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic word_t lfsrNext(word_t s);
        return s[0] ? ((s >> 1) ^ lfsrTaps) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic randBits(input int n, output word_t r);
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsrNext(lfsr);
        end
    endtask

    task automatic checkEq(input word_t got, input word_t exp, input string msg);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("MISMATCH at %0t ns: %s: got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    function automatic word_t signExtend(imm_t imm);
        return {{15{imm[16]}}, imm};
    endfunction

    // Reference behavior of each ALU function
    function automatic word_t aluModel(aluFunc_t f, word_t a, word_t b);
        case (f)
            aluSub: return a - b;
            aluAdd: return a + b;
            aluNot: return ~a;
            aluAnd: return a & b;
            aluOr: return a | b;
            aluXor: return a ^ b;
            aluSul, aluSsl: return a << b[4:0];
            aluSur: return a >> b[4:0];
            aluSsr: return $signed(a) >>> b[4:0];   // Sign fill
            aluEq: return {31'b0, a == b};
            aluNeq: return {31'b0, a != b};
            aluLt: return {31'b0, $signed(a) < $signed(b)};
            aluLeq: return {31'b0, $signed(a) <= $signed(b)};
            default: return 'x;
        endcase
    endfunction

    function automatic logic branchTaken(opcode_t op, word_t a, word_t b);
        if (op == opBeq) return a == b;
        if (op == opBne) return a != b;
        if (op == opBlt) return $signed(a) < $signed(b);
        return $signed(a) <= $signed(b);
    endfunction

    function automatic word_t encodeImm(opcode_t op, regIdx_t rx, regIdx_t ry, imm_t imm);
        return {op, rx, ry, imm};
    endfunction

    function automatic word_t encodeReg(aluFunc_t f, regIdx_t rx, regIdx_t ry, regIdx_t rz);
        return {opAlur, rx, ry, rz, 7'b0, f};
    endfunction

    // Any 32-bit constant in three instructions
    task automatic loadConst(input regIdx_t r, input word_t v);
        word_t diff;
        diff = v - signExtend(v[16:0]);
        progWords.push_back(encodeImm(opAddi, 5'd0, r, diff[31:15]));
        progWords.push_back(encodeImm(opSuli, r, r, 17'd15));
        progWords.push_back(encodeImm(opAddi, r, r, v[16:0]));
    endtask

    task automatic storeLed(input regIdx_t r);
        progWords.push_back(encodeImm(opSw, 5'd0, r, ledAddress[16:0]));
    endtask

    // Load during reset, release, wait for halt, check LEDs
    task automatic runProgram(input word_t expected, input string name);
        int holdCycles;
        int cycles;
        holdCycles = (progWords.size() > 16) ? progWords.size() : 16;
        @(negedge clk);
        reset = 1'b1;
        for (int i = 0; i < holdCycles; i++) begin
            if (i < progWords.size()) begin
                progWe = 1'b1;
                progAddr = memIndex_t'(i);
                progData = progWords[i];
            end else begin
                progWe = 1'b0;
            end
            @(negedge clk);
        end
        progWe = 1'b0;
        reset = 1'b0;
        checkEq({31'b0, halted}, 32'd0, {name, ": halted after reset"});
        cycles = 0;
        while (!halted && cycles < runLimit) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            timeoutCount++;
            $display("Timeout at %0t ns: %s did not halt within %0d cycles",
                     $time, name, runLimit);
        end else begin
            checkEq({22'b0, ledOut}, expected & 32'h3FF, name);
        end
    endtask

    task automatic regCase(input aluFunc_t f, input word_t a, input word_t b,
                           input string name);
        progWords.delete();
        loadConst(5'd1, a);
        loadConst(5'd2, b);
        progWords.push_back(encodeReg(f, 5'd1, 5'd2, 5'd3));
        storeLed(5'd3);
        progWords.push_back(haltWord);
        runProgram(aluModel(f, a, b), name);
    endtask

    task automatic immCase(input opcode_t op, input aluFunc_t f, input word_t a,
                           input imm_t imm, input string name);
        progWords.delete();
        loadConst(5'd1, a);
        progWords.push_back(encodeImm(op, 5'd1, 5'd3, imm));
        storeLed(5'd3);
        progWords.push_back(haltWord);
        runProgram(aluModel(f, a, signExtend(imm)), name);
    endtask

    task automatic aluLogicTest();
        aluFunc_t funcs[6] = '{aluSub, aluAdd, aluNot, aluAnd, aluOr, aluXor};
        opcode_t immOps[4] = '{opAddi, opAndi, opOri, opXori};
        aluFunc_t immFuncs[4] = '{aluAdd, aluAnd, aluOr, aluXor};
        word_t a;
        word_t b;
        foreach (funcs[i]) begin
            randBits(32, a);
            randBits(32, b);
            regCase(funcs[i], a, b, $sformatf("register func %0d", funcs[i]));
        end
        foreach (immOps[i]) begin
            randBits(32, a);
            randBits(17, b);
            immCase(immOps[i], immFuncs[i], a, b[16:0], $sformatf("immediate op %0d", immOps[i]));
        end
    endtask

    task automatic shiftCompareTest();
        aluFunc_t shifts[4] = '{aluSul, aluSsl, aluSur, aluSsr};
        opcode_t immShifts[4] = '{opSuli, opSsli, opSuri, opSsri};
        aluFunc_t compares[4] = '{aluEq, aluNeq, aluLt, aluLeq};
        word_t x;
        word_t y;
        foreach (shifts[i]) begin
            randBits(32, x);
            randBits(32, y);
            x[31] = 1'b1;   // Negative, so the two right shifts differ
            regCase(shifts[i], x, y, $sformatf("shift func %0d", shifts[i]));
            regCase(shifts[i], x, 32'd28, $sformatf("shift func %0d by 28", shifts[i]));
            randBits(17, y);
            immCase(immShifts[i], shifts[i], x, y[16:0], $sformatf("shift op %0d", immShifts[i]));
        end
        foreach (compares[i]) begin
            randBits(32, x);
            randBits(32, y);
            x[31] = 1'b1;
            y[31] = 1'b0;
            regCase(compares[i], x, y, $sformatf("compare %0d neg-pos", compares[i]));
            regCase(compares[i], y, x, $sformatf("compare %0d pos-neg", compares[i]));
            regCase(compares[i], x, x, $sformatf("compare %0d equal", compares[i]));
        end
    endtask

    task automatic memoryTest();
        int shiftBy[4] = '{0, 10, 20, 22};   // Walks the loaded word past the 10 LEDs
        word_t a;
        word_t c;
        word_t base;
        foreach (shiftBy[i]) begin
            randBits(32, a);
            randBits(32, c);
            randBits(9, base);
            progWords.delete();
            loadConst(5'd1, a);
            loadConst(5'd2, c);
            progWords.push_back(encodeImm(opAddi, 5'd0, 5'd4, {6'd0, base[8:0], 2'b00}));
            progWords.push_back(encodeImm(opSw, 5'd4, 5'd1, 17'd0));
            progWords.push_back(encodeImm(opSw, 5'd4, 5'd2, 17'd4));   // Neighbor word
            progWords.push_back(encodeImm(opLw, 5'd4, 5'd5, 17'd0));
            progWords.push_back(encodeImm(opSuri, 5'd5, 5'd6, imm_t'(shiftBy[i])));
            storeLed(5'd6);
            progWords.push_back(haltWord);
            runProgram(a >> shiftBy[i], $sformatf("load after store, shift %0d", shiftBy[i]));
        end
    endtask

    task automatic switchTest();
        logic [9:0] values[3];
        word_t r;
        randBits(10, r);
        values[0] = r[9:0];
        randBits(10, r);
        values[1] = r[9:0];
        values[2] = 10'h3FF;   // Wraps to zero on the LEDs
        foreach (values[i]) begin
            @(negedge clk);
            switches = values[i];
            progWords.delete();
            progWords.push_back(encodeImm(opLw, 5'd0, 5'd1, switchAddress[16:0]));
            progWords.push_back(encodeImm(opAddi, 5'd1, 5'd1, 17'd1));
            storeLed(5'd1);
            progWords.push_back(haltWord);
            runProgram({22'b0, values[i]} + 1, $sformatf("switches %h plus one", values[i]));
        end
    endtask

    task automatic branchCase(input opcode_t op, input word_t a, input word_t b);
        progWords.delete();
        loadConst(5'd1, a);
        loadConst(5'd2, b);
        progWords.push_back(encodeImm(op, 5'd1, 5'd2, 17'd3));   // Word 6 to word 10
        progWords.push_back(encodeImm(opAddi, 5'd0, 5'd3, 17'd2));
        storeLed(5'd3);
        progWords.push_back(haltWord);
        progWords.push_back(encodeImm(opAddi, 5'd0, 5'd3, 17'd1));
        storeLed(5'd3);
        progWords.push_back(haltWord);
        runProgram(branchTaken(op, a, b) ? 32'd1 : 32'd2,
                   $sformatf("branch %0d with %h, %h", op, a, b));
    endtask

    task automatic branchTest();
        opcode_t ops[4] = '{opBeq, opBne, opBlt, opBle};
        word_t x;
        word_t y;
        foreach (ops[i]) begin
            randBits(32, x);
            randBits(32, y);
            x[31] = 1'b1;   // Unsigned order would disagree
            y[31] = 1'b0;
            branchCase(ops[i], x, y);
            branchCase(ops[i], y, x);
            branchCase(ops[i], x, x);
        end
    endtask

    task automatic jalHaltTest();
        word_t n;
        int fillers;
        int jalIdx;
        randBits(2, n);
        fillers = int'(n);
        jalIdx = 1 + fillers;
        progWords.delete();
        progWords.push_back(encodeImm(opAddi, 5'd0, 5'd1, imm_t'(4 * (jalIdx + 2))));
        for (int i = 0; i < fillers; i++) begin
            progWords.push_back(encodeImm(opAddi, 5'd0, 5'd5, imm_t'(i)));
        end
        progWords.push_back(encodeImm(opJal, 5'd1, 5'd2, 17'd0));
        progWords.push_back(haltWord);   // Return lands here
        storeLed(5'd2);
        progWords.push_back(encodeImm(opJal, 5'd2, 5'd3, 17'd0));
        runProgram(word_t'(4 * (jalIdx + 1)), "JAL return address");
        repeat (8) begin
            @(negedge clk);
            checkEq({31'b0, halted}, 32'd1, "halted stays high");
        end
        // Unknown register function stops before the second store
        progWords.delete();
        progWords.push_back(encodeImm(opAddi, 5'd0, 5'd1, 17'd5));
        storeLed(5'd1);
        progWords.push_back(encodeReg(5'b11000, 5'd1, 5'd1, 5'd2));
        progWords.push_back(encodeImm(opAddi, 5'd1, 5'd1, 17'd9));
        storeLed(5'd1);
        progWords.push_back(haltWord);
        runProgram(32'd5, "halt on unknown register function");
    endtask

    initial begin
        reset = 1'b1;
        progWe = 1'b0;
        progAddr = '0;
        progData = '0;
        switches = '0;
        lfsr = lfsrSeed;
        checkCount = 0;
        errorCount = 0;
        timeoutCount = 0;

        aluLogicTest();
        shiftCompareTest();
        memoryTest();
        switchTest();
        branchTest();
        jalHaltTest();

        $display("Checks: %0d  errors: %0d  timeouts: %0d", checkCount, errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
